/* core_env.sv */
`default_nettype none

module core_env (
	input wire clock,
	input wire reset,
	input wire a_valid,
	input wire env_pkg::tl_a_t a_bits,
	output logic a_ready,
	input wire d_ready,
	output logic d_valid,
	output env_pkg::tl_d_t d_bits,
	input wire req_valid,
	input wire env_pkg::md_req_t req,
	output logic req_ready,
	input wire kill,
	input wire resp_ready,
	output logic resp_valid,
	output env_pkg::md_resp_t resp
);
	logic env_reset; // Stretched reset for both engines

	reset_stretcher reset_stretcher_inst (
		.clock(clock),
		.reset(reset),
		.env_reset(env_reset)
	);

	tl_responder tl_responder_inst (
		.clock(clock),
		.reset(env_reset),
		.a_valid(a_valid),
		.a_bits(a_bits),
		.a_ready(a_ready),
		.d_ready(d_ready),
		.d_valid(d_valid),
		.d_bits(d_bits)
	);

	muldiv_model muldiv_model_inst (
		.clock(clock),
		.reset(env_reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.kill(kill),
		.resp_ready(resp_ready),
		.resp_valid(resp_valid),
		.resp(resp)
	);

endmodule

`default_nettype wire

/* dtim_store.sv */
`default_nettype none

`include "env_params.svh"

module dtim_store (
	input wire clock,
	input wire [$clog2(`DTIM_BYTES / `BEAT_BYTES)-1:0] index,
	input wire wr_en,
	input wire [`BEAT_BYTES-1:0] wr_mask,
	input wire [`XLEN-1:0] wr_data,
	output logic [`XLEN-1:0] rd_data
);
	localparam int WORDS = `DTIM_BYTES / `BEAT_BYTES;

	logic [`XLEN-1:0] mem [WORDS];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			for (int lane = 0; lane < `BEAT_BYTES; lane++) begin
				if (wr_mask[lane])
					mem[index][8*lane +: 8] <= wr_data[8*lane +: 8];
			end
		end
	end

	assign rd_data = mem[index]; // Asynchronous read

endmodule

`default_nettype wire

/* env_params.svh */
`ifndef ENV_PARAMS_SVH
`define ENV_PARAMS_SVH

// Bus geometry
`define XLEN 32
`define BEAT_BYTES 4
`define ADDR_W 32
`define SIZE_W 4

// Cycles of reset kept after the external reset drops
`define RESET_STRETCH 5

// Data memory window
`define DTIM_BASE 32'h8000_0000
`define DTIM_BYTES 1024

// Multiply/divide stand-in
`define MD_W 64
`define MD_TAG_W 5

// Scramble keys, one per function
`define MD_KEY_MUL 64'h2cdf_52a5_5876_063e
`define MD_KEY_MULH 64'h15d0_1651_f658_3fb7
`define MD_KEY_MULHSU 64'hea39_69ed_ecfb_e137
`define MD_KEY_MULHU 64'hd13d_b50d_949c_e5e8
`define MD_KEY_DIV 64'h29bb_f66f_7f85_29ec
`define MD_KEY_DIVU 64'h8c62_9acb_10e8_fd70
`define MD_KEY_REM 64'hf5b7_d853_8da6_8fa5
`define MD_KEY_REMU 64'hbc44_0241_3138_d0e1

`endif

/* env_pkg.sv */
`default_nettype none

`include "env_params.svh"

package env_pkg;

	// TL-UL A opcodes, only Get and PutFullData are served
	typedef enum logic [2:0] {
		TL_PUT_FULL_DATA = 3'd0,
		TL_PUT_PARTIAL_DATA = 3'd1,
		TL_GET = 3'd4
	} tl_a_op_e;

	typedef enum logic [2:0] {
		TL_ACCESS_ACK = 3'd0,
		TL_ACCESS_ACK_DATA = 3'd1
	} tl_d_op_e;

	typedef struct packed {
		tl_a_op_e opcode;
		logic [2:0] param;
		logic [`SIZE_W-1:0] size; // log2 of bytes
		logic source;
		logic [`ADDR_W-1:0] address;
		logic [`BEAT_BYTES-1:0] mask;
		logic [`XLEN-1:0] data;
	} tl_a_t;

	typedef struct packed {
		tl_d_op_e opcode;
		logic [1:0] param;
		logic [`SIZE_W-1:0] size;
		logic source;
		logic [2:0] sink;
		logic denied;
		logic corrupt;
		logic [`XLEN-1:0] data;
	} tl_d_t;

	typedef struct packed {
		logic atomic;
		logic read;
		logic write;
		logic execute;
		logic cacheable;
	} pma_t;

	typedef enum logic {
		RESP_IDLE,
		RESP_RESPOND
	} resp_state_e;

	typedef enum logic [3:0] {
		MD_MUL = 4'd0,
		MD_MULH = 4'd1,
		MD_MULHSU = 4'd2,
		MD_MULHU = 4'd3,
		MD_DIV = 4'd4,
		MD_DIVU = 4'd5,
		MD_REM = 4'd6,
		MD_REMU = 4'd7
	} md_fn_e;

	typedef struct packed {
		md_fn_e fn;
		logic dw; // Low means 32-bit word op
		logic [`MD_W-1:0] in1;
		logic [`MD_W-1:0] in2;
		logic [`MD_TAG_W-1:0] tag;
	} md_req_t;

	typedef struct packed {
		logic [`MD_W-1:0] data;
		logic [`MD_TAG_W-1:0] tag;
	} md_resp_t;

endpackage

`default_nettype wire

/* muldiv_model.sv */
`default_nettype none

`include "env_params.svh"

module muldiv_model (
	input wire clock,
	input wire reset,
	input wire req_valid,
	input wire env_pkg::md_req_t req,
	output logic req_ready,
	input wire kill,
	input wire resp_ready,
	output logic resp_valid,
	output env_pkg::md_resp_t resp
);
	logic busy, settle, done;
	logic req_fire, resp_fire;
	logic [`MD_W-1:0] raw;
	logic [`MD_W-1:0] result;
	env_pkg::md_resp_t resp_q;

	always_comb begin
		case (req.fn)
			env_pkg::MD_MUL: raw = (req.in1 + req.in2) ^ `MD_KEY_MUL;
			env_pkg::MD_MULH: raw = (req.in1 + req.in2) ^ `MD_KEY_MULH;
			env_pkg::MD_MULHSU: raw = (req.in1 - req.in2) ^ `MD_KEY_MULHSU;
			env_pkg::MD_MULHU: raw = (req.in1 + req.in2) ^ `MD_KEY_MULHU;
			env_pkg::MD_DIV: raw = (req.in1 - req.in2) ^ `MD_KEY_DIV;
			env_pkg::MD_DIVU: raw = (req.in1 - req.in2) ^ `MD_KEY_DIVU;
			env_pkg::MD_REM: raw = (req.in1 - req.in2) ^ `MD_KEY_REM;
			env_pkg::MD_REMU: raw = (req.in1 - req.in2) ^ `MD_KEY_REMU;
			default: raw = req.in1 - req.in2;
		endcase
	end

	// Word ops sign-extend the low half
	assign result = req.dw ? raw : {{(`MD_W - 32){raw[31]}}, raw[31:0]};

	assign req_ready = !busy && !reset;
	assign req_fire = req_valid && req_ready;
	assign resp_valid = done;
	assign resp_fire = resp_valid && resp_ready;
	assign resp = resp_q;

	always_ff @(posedge clock) begin
		if (reset || kill) begin
			busy <= 1'b0;
			settle <= 1'b0;
			done <= 1'b0;
		end else begin
			if (req_fire) begin
				busy <= 1'b1;
				settle <= 1'b1; // One wait edge before done
			end
			if (busy && settle)
				settle <= 1'b0;
			if (busy && !settle && !done)
				done <= 1'b1;
			if (resp_fire) begin
				busy <= 1'b0;
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			resp_q.data <= result;
			resp_q.tag <= req.tag;
		end
	end

	resp_needs_req: assert property (@(posedge clock) disable iff (reset)
		resp_valid |-> busy && $past(busy));

endmodule

`default_nettype wire

/* pma_map.sv */
`default_nettype none

`include "env_params.svh"

module pma_map (
	input wire [`ADDR_W-1:0] address,
	input wire [`SIZE_W-1:0] log2len,
	output env_pkg::pma_t perm
);
	logic [`ADDR_W-1:0] size_mask;
	logic [`ADDR_W-1:0] last_addr;

	// Bits are atomic, read, write, execute, cacheable
	function automatic env_pkg::pma_t region_perm(input logic [`ADDR_W-1:0] addr);
		logic [4:0] modes;
		modes = 5'b00000;
		if (addr < 32'h0000_1000)
			modes = 5'b11110; // Debug controller
		if (addr >= 32'h0000_3000 && addr < 32'h0000_4000)
			modes = 5'b11110; // Error device
		if (addr >= 32'h0001_0000 && addr < 32'h0002_0000)
			modes = 5'b01010; // Rom
		// Clint takes writes but no reads
		if (addr >= 32'h0200_0000 && addr < 32'h0201_0000)
			modes = 5'b10100;
		if (addr >= 32'h0c00_0000 && addr < 32'h1000_0000)
			modes = 5'b11100; // Interrupt controller
		if (addr >= 32'h6000_0000 && addr < 32'h8000_0000)
			modes = 5'b01110; // Mmio
		if (addr >= `DTIM_BASE && addr < `DTIM_BASE + `DTIM_BYTES)
			modes = 5'b11110;
		return env_pkg::pma_t'(modes);
	endfunction

	assign size_mask = (`ADDR_W'(1) << log2len) - `ADDR_W'(1);
	assign last_addr = address + size_mask;

	always_comb begin
		// Both ends must sit in regions that allow it
		perm = env_pkg::pma_t'(region_perm(address) & region_perm(last_addr));
		if ((address & size_mask) != '0) begin
			perm.atomic = 1'b0;
			perm.read = 1'b0;
			perm.write = 1'b0;
			perm.cacheable = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* reset_stretcher.sv */
`default_nettype none

`include "env_params.svh"

module reset_stretcher (
	input wire clock,
	input wire reset,
	output logic env_reset
);
	localparam int CNT_W = $clog2(`RESET_STRETCH + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= CNT_W'(`RESET_STRETCH);
		end else if (count != '0) begin
			count <= count - 1'b1; // Drain after release
		end
	end

	assign env_reset = reset || (count != '0);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_core_env -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0

/* sources.f */
+incdir+.
env_pkg.sv
reset_stretcher.sv
pma_map.sv
dtim_store.sv
tl_responder.sv
muldiv_model.sv
core_env.sv
tb_core_env.sv

/* tb_core_env.sv */
`default_nettype none

`include "env_params.svh"

module tb_core_env;
	localparam int PERIOD = 100;
	localparam int DRIVE = 10; // Input delay after the rising edge
	localparam int RESET_CYCLES = 10;
	localparam int N_TL = 26;
	localparam int N_MD = 20;
	localparam int LIMIT =
		(RESET_CYCLES + `RESET_STRETCH + N_TL * 160 + N_MD * 8 + 50) * PERIOD;

	// Expected D response, staged by the stimulus and latched on the A transfer
	typedef struct packed {
		logic [2:0] beats;
		env_pkg::tl_d_op_e op;
		logic [`SIZE_W-1:0] size;
		logic source;
		logic denied;
		logic [7:0][`XLEN-1:0] words;
	} d_expect_t;

	logic clock, reset;
	logic a_valid, a_ready, d_ready, d_valid;
	env_pkg::tl_a_t a_bits;
	env_pkg::tl_d_t d_bits;
	logic req_valid, req_ready, kill, resp_ready, resp_valid;
	env_pkg::md_req_t req;
	env_pkg::md_resp_t resp;

	logic [31:0] lfsr = 32'h8def_5e32;
	logic [`XLEN-1:0] shadow [`DTIM_BYTES / 4]; // Last word written per dtim index
	logic [3:0] low_cycles = 4'd0;
	logic stall_en = 1'b0;
	logic kill_phase = 1'b0;
	logic md_busy = 1'b0;
	logic [2:0] beat_n = 3'd0;
	d_expect_t nxt_exp;
	d_expect_t cur_exp = '0;
	env_pkg::md_resp_t md_exp;
	logic d_fire, md_fire;

	core_env core_env_inst (.*);

	assign d_fire = d_valid && d_ready;
	assign md_fire = req_valid && req_ready;

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(LIMIT);
		$display("Timeout: the run did not finish within %0d time units", LIMIT);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // Galois step
		end
		return v;
	endfunction

	function automatic logic [`MD_W-1:0] md_expect(input env_pkg::md_fn_e fn, input logic dw,
			input logic [`MD_W-1:0] in1, input logic [`MD_W-1:0] in2);
		logic [`MD_W-1:0] key, r;
		case (fn)
			env_pkg::MD_MUL: key = `MD_KEY_MUL;
			env_pkg::MD_MULH: key = `MD_KEY_MULH;
			env_pkg::MD_MULHSU: key = `MD_KEY_MULHSU;
			env_pkg::MD_MULHU: key = `MD_KEY_MULHU;
			env_pkg::MD_DIV: key = `MD_KEY_DIV;
			env_pkg::MD_DIVU: key = `MD_KEY_DIVU;
			env_pkg::MD_REM: key = `MD_KEY_REM;
			default: key = `MD_KEY_REMU;
		endcase
		r = (fn inside {env_pkg::MD_MUL, env_pkg::MD_MULH, env_pkg::MD_MULHU}) ?
			in1 + in2 : in1 - in2;
		r = r ^ key;
		return dw ? r : {{32{r[31]}}, r[31:0]};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("MISMATCH at %0t: %s expected %h, got %h",
			$time, name, expected, actual);
		$display("TB FAILED");
		$fatal(1, "value check failed");
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "protocol check failed");
	endtask

	always @(posedge clock) begin
		low_cycles <= reset ? 4'd0 : (low_cycles == 4'hf ? low_cycles : low_cycles + 4'd1);
		if (a_valid && a_ready) begin
			cur_exp <= nxt_exp;
			beat_n <= 3'd0;
		end else if (d_fire) begin
			beat_n <= beat_n + 3'd1;
		end
		if (kill || reset)
			md_busy <= 1'b0;
		else if (md_fire)
			md_busy <= 1'b1;
		else if (resp_valid && resp_ready)
			md_busy <= 1'b0;
	end

	reset_hold: assert property (@(posedge clock)
		reset || low_cycles < 4'(`RESET_STRETCH) |-> !a_ready && !req_ready)
		else report_failure("a_ready or req_ready high during the stretched reset");
	reset_release: assert property (@(posedge clock)
		!reset && low_cycles == 4'(`RESET_STRETCH) |-> a_ready && req_ready)
		else report_failure("a_ready or req_ready still low after the reset stretch");

	d_start: assert property (@(posedge clock) a_valid && a_ready |=> d_valid)
		else report_failure("d_valid did not rise on the edge after the A transfer");
	d_extra: assert property (@(posedge clock) d_valid |-> beat_n < cur_exp.beats)
		else report_failure("d_valid high with no D beat outstanding");
	d_op: assert property (@(posedge clock) d_fire |-> d_bits.opcode == cur_exp.op)
		else report_mismatch("d_bits.opcode", 64'($sampled(cur_exp.op)),
			64'($sampled(d_bits.opcode)));
	d_param: assert property (@(posedge clock) d_fire |-> d_bits.param == 2'b00)
		else report_mismatch("d_bits.param", 64'h0, 64'($sampled(d_bits.param)));
	d_size: assert property (@(posedge clock) d_fire |-> d_bits.size == cur_exp.size)
		else report_mismatch("d_bits.size", 64'($sampled(cur_exp.size)),
			64'($sampled(d_bits.size)));
	d_source: assert property (@(posedge clock) d_fire |-> d_bits.source == cur_exp.source)
		else report_mismatch("d_bits.source", 64'($sampled(cur_exp.source)),
			64'($sampled(d_bits.source)));
	d_denied: assert property (@(posedge clock) d_fire |-> d_bits.denied == cur_exp.denied)
		else report_mismatch("d_bits.denied", 64'($sampled(cur_exp.denied)),
			64'($sampled(d_bits.denied)));
	d_corrupt: assert property (@(posedge clock) d_fire |-> d_bits.corrupt == cur_exp.denied)
		else report_mismatch("d_bits.corrupt", 64'($sampled(cur_exp.denied)),
			64'($sampled(d_bits.corrupt)));
	d_data: assert property (@(posedge clock)
		d_fire && (cur_exp.op == env_pkg::TL_ACCESS_ACK_DATA || cur_exp.denied)
		|-> d_bits.data == cur_exp.words[beat_n])
		else report_mismatch("d_bits.data", 64'($sampled(cur_exp.words[beat_n])),
			64'($sampled(d_bits.data)));

	md_rise: assert property (@(posedge clock) $rose(resp_valid) |-> $past(md_fire, 3))
		else report_failure("resp_valid rose other than two edges after a request");
	md_late: assert property (@(posedge clock)
		$past(md_fire, 3) && !kill_phase |-> $rose(resp_valid))
		else report_failure("no response two edges after the request");
	md_data: assert property (@(posedge clock)
		resp_valid && resp_ready |-> resp.data == md_exp.data)
		else report_mismatch("resp.data", $sampled(md_exp.data), $sampled(resp.data));
	md_tag: assert property (@(posedge clock)
		resp_valid && resp_ready |-> resp.tag == md_exp.tag)
		else report_mismatch("resp.tag", 64'($sampled(md_exp.tag)), 64'($sampled(resp.tag)));
	md_hold: assert property (@(posedge clock) md_busy |-> !req_ready)
		else report_failure("req_ready high while a request is in flight");
	md_free: assert property (@(posedge clock)
		!reset && low_cycles >= 4'(`RESET_STRETCH) && !md_busy |-> req_ready)
		else report_failure("req_ready low with no request in flight");
	md_kill: assert property (@(posedge clock) kill_phase |-> !resp_valid)
		else report_failure("resp_valid rose for a killed request");

	// d_ready stalls only while stall_en was set at the edge
	initial begin
		logic stall;
		d_ready = 1'b1;
		forever begin
			@(posedge clock);
			stall = stall_en;
			#(DRIVE);
			d_ready = stall ? 1'(random_bits(1)) : 1'b1;
		end
	end

	task automatic tl_access(input env_pkg::tl_a_op_e op, input logic [`SIZE_W-1:0] size,
			input logic [`ADDR_W-1:0] addr, input logic deny, input logic stall);
		logic [`XLEN-1:0] data;
		logic [7:0] idx;
		logic in_dtim;
		@(posedge clock);
		#(DRIVE);
		in_dtim = addr >= `DTIM_BASE && addr < `DTIM_BASE + `DTIM_BYTES;
		idx = 8'((addr - `DTIM_BASE) >> 2);
		data = `XLEN'(random_bits(`XLEN));
		nxt_exp.beats = (op == env_pkg::TL_GET && size > 4'd2) ?
			3'(1 << (size - 4'd2)) : 3'd1;
		nxt_exp.op = op == env_pkg::TL_GET ?
			env_pkg::TL_ACCESS_ACK_DATA : env_pkg::TL_ACCESS_ACK;
		nxt_exp.size = size;
		nxt_exp.source = 1'(random_bits(1));
		nxt_exp.denied = deny;
		for (int i = 0; i < 8; i++)
			nxt_exp.words[3'(i)] = (deny || !in_dtim) ? '0 : shadow[idx + 8'(i)];
		a_bits.opcode = op;
		a_bits.param = 3'd0;
		a_bits.size = size;
		a_bits.source = nxt_exp.source;
		a_bits.address = addr;
		a_bits.mask = 4'hf;
		a_bits.data = data;
		a_valid = 1'b1;
		stall_en = stall;
		do @(negedge clock); while (!a_ready);
		@(posedge clock);
		#(DRIVE);
		a_valid = 1'b0;
		do @(negedge clock); while (beat_n != cur_exp.beats);
		stall_en = 1'b0;
		if (op == env_pkg::TL_PUT_FULL_DATA && !deny && in_dtim)
			shadow[idx] = data;
	endtask

	// A negative kill_after runs the request to its response
	task automatic md_access(input env_pkg::md_fn_e fn, input logic dw, input int kill_after);
		@(posedge clock);
		#(DRIVE);
		req.fn = fn;
		req.dw = dw;
		req.in1 = random_bits(64);
		req.in2 = random_bits(64);
		req.tag = `MD_TAG_W'(random_bits(`MD_TAG_W));
		md_exp.data = md_expect(fn, dw, req.in1, req.in2);
		md_exp.tag = req.tag;
		kill_phase = kill_after >= 0;
		req_valid = 1'b1;
		do @(negedge clock); while (!req_ready);
		@(posedge clock);
		#(DRIVE);
		req_valid = 1'b0;
		if (kill_after >= 0) begin
			repeat (kill_after) begin
				@(posedge clock);
				#(DRIVE);
			end
			kill = 1'b1;
			@(posedge clock);
			#(DRIVE);
			kill = 1'b0;
			repeat (4) @(posedge clock);
			#(DRIVE);
			kill_phase = 1'b0;
		end else begin
			do @(negedge clock); while (!resp_valid);
		end
	endtask

	initial begin
		logic [31:0] blk;
		reset = 1'b1;
		a_valid = 1'b0;
		a_bits = '0;
		req_valid = 1'b0;
		req = '0;
		kill = 1'b0;
		resp_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE);
		reset = 1'b0;
		do @(negedge clock); while (!a_ready);
		for (int w = 0; w < 8; w++)
			tl_access(env_pkg::TL_PUT_FULL_DATA, 4'd2,
				`DTIM_BASE + 32'(4 * w), 1'b0, 1'b0);
		for (int n = 0; n < 4; n++) begin
			blk = 32'(16 * (n % 2));
			tl_access(env_pkg::TL_PUT_FULL_DATA, 4'd2,
				`DTIM_BASE + blk + 32'(4 * random_bits(2)), 1'b0, 1'b0);
			tl_access(env_pkg::TL_GET, 4'd4, `DTIM_BASE + blk, 1'b0, 1'b1);
		end
		tl_access(env_pkg::TL_GET, 4'd2, 32'h0200_0000, 1'b1, 1'b0); // Clint lacks R
		tl_access(env_pkg::TL_GET, 4'd2, `DTIM_BASE + 32'h42, 1'b1, 1'b0);
		tl_access(env_pkg::TL_PUT_FULL_DATA, 4'd2, `DTIM_BASE + 32'h40, 1'b0, 1'b0);
		tl_access(env_pkg::TL_PUT_FULL_DATA, 4'd3, `DTIM_BASE + 32'h40, 1'b1, 1'b0);
		tl_access(env_pkg::TL_GET, 4'd2, `DTIM_BASE + 32'h40, 1'b0, 1'b0); // Old word
		tl_access(env_pkg::TL_GET, 4'd3, 32'h0001_0000, 1'b0, 1'b1); // Rom reads zero
		for (int f = 0; f < 8; f++) begin
			md_access(env_pkg::md_fn_e'(4'(f)), 1'b1, -1);
			md_access(env_pkg::md_fn_e'(4'(f)), 1'b0, -1);
		end
		md_access(env_pkg::MD_DIV, 1'b1, 0);
		md_access(env_pkg::MD_MUL, 1'b0, 1);
		md_access(env_pkg::MD_REMU, 1'b1, -1);
		repeat (4) @(posedge clock);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tl_responder.sv */
`default_nettype none

`include "env_params.svh"

module tl_responder (
	input wire clock,
	input wire reset,
	input wire a_valid,
	input wire env_pkg::tl_a_t a_bits,
	output logic a_ready,
	input wire d_ready,
	output logic d_valid,
	output env_pkg::tl_d_t d_bits
);
	localparam int LANE_W = $clog2(`BEAT_BYTES);
	localparam int IDX_W = $clog2(`DTIM_BYTES / `BEAT_BYTES);

	env_pkg::resp_state_e state;
	env_pkg::tl_a_t req_q;
	env_pkg::pma_t perm;
	logic [`ADDR_W-1:0] offset;
	logic [`ADDR_W-1:0] next_offset;
	logic [`ADDR_W-1:0] beat_addr;
	logic [`XLEN-1:0] rd_data;
	logic is_get, is_put, in_dtim, oversize, denied, last;
	logic a_fire, d_fire, wr_en;

	pma_map pma_map_inst (
		.address(req_q.address),
		.log2len(req_q.size),
		.perm(perm)
	);

	dtim_store dtim_store_inst (
		.clock(clock),
		.index(beat_addr[LANE_W +: IDX_W]),
		.wr_en(wr_en),
		.wr_mask(req_q.mask),
		.wr_data(req_q.data),
		.rd_data(rd_data)
	);

	assign is_get = req_q.opcode == env_pkg::TL_GET;
	assign is_put = req_q.opcode == env_pkg::TL_PUT_FULL_DATA;
	assign oversize = req_q.size > `SIZE_W'(LANE_W); // Puts are one beat
	assign denied = !(is_get || is_put) || (is_get && !perm.read) ||
		(is_put && (!perm.write || oversize));

	assign next_offset = offset + `ADDR_W'(`BEAT_BYTES);
	assign last = !is_get || next_offset >= (`ADDR_W'(1) << req_q.size);
	assign beat_addr = {req_q.address[`ADDR_W-1:LANE_W], {LANE_W{1'b0}}} + offset;
	assign in_dtim = beat_addr >= `DTIM_BASE && beat_addr < `DTIM_BASE + `DTIM_BYTES;

	assign d_valid = state == env_pkg::RESP_RESPOND && !reset;
	assign d_fire = d_valid && d_ready;
	assign a_ready = !reset && (state == env_pkg::RESP_IDLE || (last && d_fire));
	assign a_fire = a_valid && a_ready;
	assign wr_en = d_fire && is_put && !denied && in_dtim; // Commit with the ack

	always_comb begin
		d_bits.opcode = is_get ? env_pkg::TL_ACCESS_ACK_DATA : env_pkg::TL_ACCESS_ACK;
		d_bits.param = 2'b00;
		d_bits.size = req_q.size;
		d_bits.source = req_q.source;
		d_bits.sink = 3'b000;
		d_bits.denied = denied;
		d_bits.corrupt = denied;
		// Permitted regions outside the dtim read as zero
		d_bits.data = (denied || !in_dtim) ? '0 : rd_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= env_pkg::RESP_IDLE;
			offset <= '0;
		end else begin
			if (d_fire) begin
				if (last)
					state <= env_pkg::RESP_IDLE;
				else
					offset <= next_offset;
			end
			if (a_fire) begin
				state <= env_pkg::RESP_RESPOND;
				offset <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (a_fire)
			req_q <= a_bits;
	end

	d_hold: assert property (@(posedge clock) disable iff (reset)
		d_valid && !d_ready |=> d_valid && $stable(d_bits));

	// Ready mid-response means the response ends on this edge
	a_only_on_last: assert property (@(posedge clock) disable iff (reset)
		state == env_pkg::RESP_RESPOND && a_ready |=>
		state == env_pkg::RESP_IDLE || offset == '0);

endmodule

`default_nettype wire
